// File: logic/zorroPkg.sv
// shared zorro iii slave constants; the autoconfig table is fixed at build time and has 16 registers
package zorroPkg;

	// full-cycle controller states
	typedef enum logic [2:0] {
		StIdle,
		StMatch,
		StData,
		StWriteData,
		StDtack
	} zorroState_t;

	// logical data word and its byte lanes
	localparam int BusDataBits = 32;
	localparam int LaneCount = 4;

	// configuration space sits at ff00.0000
	localparam logic [15:0] CfgSpaceHi = 16'hFF00;

	// A8 on top, then A7..A2
	localparam int CfgIndexBits = 7;

	// register n at byte offset 4n, high nibble first
	// low nibble lives 0x100 above
	localparam logic [0:15][7:0] CfgRom = {
		8'h81, // zorro iii board, 64k window
		8'h5A, // product number
		8'h30, // flags
		8'h00,
		8'h1F, // manufacturer high byte
		8'hA3, // manufacturer low byte
		8'h00, // serial number
		8'h00,
		8'h00,
		8'h01,
		8'h00, // no boot rom vector
		8'h00,
		8'h00,
		8'h00,
		8'h00,
		8'h00
	};

	// byte offsets of the two writable autoconfig locations
	localparam logic [8:0] CfgBaseOffset = 9'h044;
	localparam logic [8:0] CfgShutupOffset = 9'h04C;

endpackage

// File: logic/zorroAddrDecode.sv
// address is taken on clk, not on the nFCS edge; AD31..8 must still be valid on the first clk with nFCS low
`timescale 1ns/1ps

module zorroAddrDecode import zorroPkg::*; (
	input  logic                   clk,
	input  logic                   nIORST,
	input  logic                   nFCS_i,
	input  logic [1:0]             FC_i,
	input  logic [7:2]             A_i,
	input  logic [31:8]            adIn_i,
	input  logic                   nCFGINN_i,
	input  logic                   configured_i,
	input  logic                   shutup_i,
	input  logic [15:0]            base_i,
	input  logic                   cycleIdle_i,
	output logic [BusDataBits-1:0] addr_o,
	output logic                   cfgHit_o,
	output logic                   cardHit_o,
	output logic                   nSLAVEN_o
);

	logic [BusDataBits-1:0] addrQ;
	logic [1:0] fcQ;
	logic fcOk;
	logic cfgSpace;
	logic cardSpace;

	// full address, long aligned
	always_ff @(posedge clk) begin
		if (cycleIdle_i && !nFCS_i) begin
			addrQ <= {adIn_i, A_i, 2'b00};
		end
	end

	// memory space code kept with the address
	always_ff @(posedge clk) begin
		if (!nIORST) begin
			fcQ <= 2'b00;
		end else if (cycleIdle_i && !nFCS_i) begin
			fcQ <= FC_i;
		end
	end

	// user or supervisor data only
	assign fcOk = fcQ[0] ^ fcQ[1];

	assign cfgSpace = (addrQ[31:16] == CfgSpaceHi);
	assign cardSpace = (addrQ[31:16] == base_i);

	// config space answers only while unconfigured and chained in
	assign cfgHit_o = cfgSpace && fcOk && !configured_i && !shutup_i && !nCFGINN_i;

	// 64k card window at the assigned base
	assign cardHit_o = cardSpace && fcOk && configured_i;

	// held off until the address of this cycle is in
	assign nSLAVEN_o = !(!nFCS_i && !cycleIdle_i && (cfgHit_o || cardHit_o));

	assign addr_o = addrQ;

endmodule

// File: logic/zorroAutoconfig.sv
// only the base write at 0x44 and the shut-up write at 0x4C are decoded; registers above 15 read as unused
`timescale 1ns/1ps

module zorroAutoconfig import zorroPkg::*; (
	input  logic                    clk,
	input  logic                    nIORST,
	input  logic                    nCFGINN_i,
	input  logic [CfgIndexBits-1:0] cfgIndex_i,
	input  logic                    cfgWe_i,
	input  logic [BusDataBits-1:0]  wrWord_i,
	output logic [3:0]              cfgNibble_o,
	output logic                    configured_o,
	output logic                    shutup_o,
	output logic [15:0]             base_o,
	output logic                    nCFGOUTN_o
);

	logic [5:0] regNum;
	logic lowNibble;
	logic [7:0] regByte;
	logic [3:0] rawNibble;
	logic baseWrite;
	logic shutupWrite;
	logic configuredQ;
	logic shutupQ;
	logic [15:0] baseQ;

	// A8 picks the low nibble, A7..A2 the register
	assign regNum = cfgIndex_i[5:0];
	assign lowNibble = cfgIndex_i[6];

	always_comb begin
		if (regNum < 6'd16) begin
			regByte = CfgRom[regNum[3:0]];
		end else begin
			regByte = 8'h00;
		end
	end

	assign rawNibble = lowNibble ? regByte[3:0] : regByte[7:4];

	// register 0 reads true, every other one inverted
	assign cfgNibble_o = (regNum == 6'd0) ? rawNibble : ~rawNibble;

	// writes only count while we are the card being configured
	assign baseWrite = cfgWe_i && !nCFGINN_i && (cfgIndex_i == CfgBaseOffset[8:2]);
	assign shutupWrite = cfgWe_i && !nCFGINN_i && (cfgIndex_i == CfgShutupOffset[8:2]);

	always_ff @(posedge clk) begin
		if (!nIORST) begin
			configuredQ <= 1'b0;
			shutupQ <= 1'b0;
		end else begin
			if (baseWrite) begin
				configuredQ <= 1'b1;
			end
			if (shutupWrite) begin
				shutupQ <= 1'b1;
			end
		end
	end

	// base comes from D31..D16 of the write
	always_ff @(posedge clk) begin
		if (baseWrite) begin
			baseQ <= wrWord_i[31:16];
		end
	end

	// pass the chain on one clk after the write lands
	always_ff @(posedge clk) begin
		if (!nIORST) begin
			nCFGOUTN_o <= 1'b1;
		end else if (configuredQ || shutupQ) begin
			nCFGOUTN_o <= 1'b0;
		end
	end

	assign configured_o = configuredQ;
	assign shutup_o = shutupQ;
	assign base_o = baseQ;

endmodule

// File: logic/zorroCycleCtrl.sv
// full cycles only, no multiple-transfer or bus error; nFCS high in any state ends the cycle
`timescale 1ns/1ps

module zorroCycleCtrl import zorroPkg::*; #(
	parameter int MemWordBits = 8
) (
	input  logic                   clk,
	input  logic                   nIORST,
	input  logic                   nFCS_i,
	input  logic                   DOE_i,
	input  logic                   READ_i,
	input  logic [LaneCount-1:0]   nDS_i,
	input  logic [31:8]            adIn_i,
	input  logic [7:0]             sdIn_i,
	input  logic                   cfgHit_i,
	input  logic                   cardHit_i,
	input  logic [BusDataBits-1:0] addr_i,
	output logic                   cycleIdle_o,
	output logic [LaneCount-1:0]   laneWe_o,
	output logic                   laneRe_o,
	output logic [MemWordBits-1:0] wordIndex_o,
	output logic [BusDataBits-1:0] wrWord_o,
	output logic                   cfgWe_o,
	output logic                   nDTACK_o
);

	zorroState_t state;
	logic fcsSeen;
	logic cfgCycle;
	logic rdIssued;
	logic anyStrobe;
	logic [LaneCount-1:0] strobeQ;
	logic [BusDataBits-1:0] wrWordQ;

	assign anyStrobe = (nDS_i != '1);

	always_ff @(posedge clk) begin
		if (!nIORST) begin
			state <= StIdle;
			fcsSeen <= 1'b0;
			cfgCycle <= 1'b0;
			rdIssued <= 1'b0;
			strobeQ <= '0;
		end else begin
			// set on the clk that latches the address
			fcsSeen <= (state == StIdle) && !nFCS_i;
			rdIssued <= 1'b0;
			if (nFCS_i) begin
				state <= StIdle;
			end else begin
				case (state)
					StIdle: begin
						if (fcsSeen && (cfgHit_i || cardHit_i)) begin
							state <= StMatch;
							cfgCycle <= cfgHit_i;
						end
					end
					// wait for the master to open data time
					StMatch: begin
						if (DOE_i) begin
							state <= StData;
						end
					end
					StData: begin
						if (READ_i) begin
							// memory needs one clk for its registered read
							if (cfgCycle || rdIssued) begin
								state <= StDtack;
							end else begin
								rdIssued <= 1'b1;
							end
						end else if (anyStrobe) begin
							strobeQ <= ~nDS_i;
							state <= StWriteData;
						end
					end
					StWriteData: begin
						state <= StDtack;
					end
					// hold until nFCS rises
					StDtack: begin
						state <= StDtack;
					end
					default: begin
						state <= StIdle;
					end
				endcase
			end
		end
	end

	// bus lanes back into D31..D0
	always_ff @(posedge clk) begin
		if (state == StData && !READ_i && anyStrobe) begin
			wrWordQ <= {adIn_i[31:24], sdIn_i, adIn_i[23:8]};
		end
	end

	// free for a new address only before the first latch
	assign cycleIdle_o = (state == StIdle) && !fcsSeen;

	assign laneRe_o = (state == StData) && READ_i && !cfgCycle && !rdIssued;
	assign laneWe_o = (state == StWriteData && !cfgCycle) ? strobeQ : '0;
	assign cfgWe_o = (state == StWriteData) && cfgCycle;

	// longword index inside the card window, aliased
	assign wordIndex_o = addr_i[MemWordBits+1:2];
	assign wrWord_o = wrWordQ;

	assign nDTACK_o = !(state == StDtack && !nFCS_i);

endmodule

// File: logic/byteLaneRam.sv
// contents are undefined after power-up and are not cleared by reset
`timescale 1ns/1ps

module byteLaneRam #(
	parameter int MemWordBits = 8
) (
	input  logic                   clk,
	input  logic                   we_i,
	input  logic                   re_i,
	input  logic [MemWordBits-1:0] index_i,
	input  logic [7:0]             wrByte_i,
	output logic [7:0]             rdByte_o
);

	logic [7:0] mem [2**MemWordBits];

	// one byte per longword
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[index_i] <= wrByte_i;
		end
	end

	// registered read
	// output holds until the next read pulse
	always_ff @(posedge clk) begin
		if (re_i) begin
			rdByte_o <= mem[index_i];
		end
	end

endmodule

// File: logic/zorroDataDrive.sv
// drives data only for slave reads; the board top owns the AD and SD tristate pads
`timescale 1ns/1ps

module zorroDataDrive import zorroPkg::*; (
	input  logic                      cfgSel_i,
	input  logic [LaneCount-1:0][7:0] laneBytes_i,
	input  logic [3:0]                cfgNibble_i,
	input  logic                      nSLAVEN_i,
	input  logic                      DOE_i,
	input  logic                      READ_i,
	output logic [31:8]               adOut_o,
	output logic [7:0]                sdOut_o,
	output logic                      dataOe_o
);

	logic [BusDataBits-1:0] rdWord;

	// config reads return one nibble in D31..28
	always_comb begin
		if (cfgSel_i) begin
			rdWord = {cfgNibble_i, {(BusDataBits-4){1'b0}}};
		end else begin
			// lane 3 is D31..24
			rdWord = laneBytes_i;
		end
	end

	// D23..16 goes out on SD, D15..0 on AD23..8
	assign adOut_o[31:24] = rdWord[31:24];
	assign sdOut_o = rdWord[23:16];
	assign adOut_o[23:8] = rdWord[15:0];

	// only while selected and the master opens data time
	assign dataOe_o = !nSLAVEN_i && DOE_i && READ_i;

endmodule

// File: logic/zorroSlaveTop.sv
// card memory is 2^MemWordBits longwords mirrored across the 64k window; no pads inside
`timescale 1ns/1ps

module zorroSlaveTop import zorroPkg::*; #(
	parameter int MemWordBits = 8
) (
	input  logic                 clk,
	input  logic                 nIORST,
	input  logic                 nFCS_i,
	input  logic                 READ_i,
	input  logic                 DOE_i,
	input  logic [LaneCount-1:0] nDS_i,
	input  logic [1:0]           FC_i,
	input  logic [7:2]           A_i,
	input  logic [31:8]          adIn_i,
	input  logic [7:0]           sdIn_i,
	input  logic                 nCFGINN_i,
	output logic                 nSLAVEN_o,
	output logic                 nDTACK_o,
	output logic                 nCFGOUTN_o,
	output logic [31:8]          adOut_o,
	output logic [7:0]           sdOut_o,
	output logic                 dataOe_o
);

	logic [BusDataBits-1:0] addr;
	logic cfgHit, cardHit, cycleIdle;
	logic configured, shutup;
	logic [15:0] base;
	logic [3:0] cfgNibble;
	logic [LaneCount-1:0] laneWe;
	logic laneRe, cfgWe;
	logic [MemWordBits-1:0] wordIndex;
	logic [BusDataBits-1:0] wrWord;
	logic [LaneCount-1:0][7:0] laneBytes;

	zorroAddrDecode addrDecode (
		.clk, .nIORST, .nFCS_i, .FC_i, .A_i, .adIn_i, .nCFGINN_i,
		.configured_i(configured), .shutup_i(shutup), .base_i(base),
		.cycleIdle_i(cycleIdle), .addr_o(addr), .cfgHit_o(cfgHit),
		.cardHit_o(cardHit), .nSLAVEN_o
	);

	// index is A8 then A7..A2
	zorroAutoconfig autoconfig (
		.clk, .nIORST, .nCFGINN_i, .cfgIndex_i({addr[8], addr[7:2]}),
		.cfgWe_i(cfgWe), .wrWord_i(wrWord), .cfgNibble_o(cfgNibble),
		.configured_o(configured), .shutup_o(shutup), .base_o(base), .nCFGOUTN_o
	);

	zorroCycleCtrl #(.MemWordBits(MemWordBits)) cycleCtrl (
		.clk, .nIORST, .nFCS_i, .DOE_i, .READ_i, .nDS_i, .adIn_i, .sdIn_i,
		.cfgHit_i(cfgHit), .cardHit_i(cardHit), .addr_i(addr),
		.cycleIdle_o(cycleIdle), .laneWe_o(laneWe), .laneRe_o(laneRe),
		.wordIndex_o(wordIndex), .wrWord_o(wrWord), .cfgWe_o(cfgWe), .nDTACK_o
	);

	// lane k holds D(8k+7..8k)
	for (genvar k = 0; k < LaneCount; k++) begin : genLane
		byteLaneRam #(.MemWordBits(MemWordBits)) laneRam (
			.clk, .we_i(laneWe[k]), .re_i(laneRe), .index_i(wordIndex),
			.wrByte_i(wrWord[8*k +: 8]), .rdByte_o(laneBytes[k])
		);
	end

	zorroDataDrive dataDrive (
		.cfgSel_i(cfgHit), .laneBytes_i(laneBytes), .cfgNibble_i(cfgNibble),
		.nSLAVEN_i(nSLAVEN_o), .DOE_i, .READ_i, .adOut_o, .sdOut_o, .dataOe_o
	);

endmodule

// File: test/zorroSlave_props.sv
// needs a free-running clk and nIORST driven low from time zero for the reset rules to hold
`timescale 1ns/1ps

module zorroSlaveProps (
	input logic clk,
	input logic nIORST,
	input logic nFCS_i,
	input logic nDTACK_i,
	input logic nSLAVEN_i,
	input logic dataOe_i,
	input logic nCFGOUTN_i
);

	// acknowledge only inside a cycle and held until the master ends it
	dtackInCycle: assert property (@(posedge clk) disable iff (!nIORST)
		!nDTACK_i |-> !nFCS_i ##1 (nFCS_i || !nDTACK_i))
		else $error("nDTACK low outside a cycle or released before nFCS rose");

	// drivers on only for our own reads
	oeNeedsSlave: assert property (@(posedge clk) disable iff (!nIORST) dataOe_i |-> !nSLAVEN_i)
		else $error("data drivers enabled without nSLAVEN");

	// chain output only comes back through reset
	chainHeld: assert property (@(posedge clk) $rose(nCFGOUTN_i) |-> !$past(nIORST))
		else $error("nCFGOUTN rose without reset");

	dtackAfterReset: assert property (@(posedge clk) $rose(nIORST) |-> nDTACK_i)
		else $error("nDTACK low right after reset release");

endmodule

bind zorroSlaveTop zorroSlaveProps props_i (
	.clk, .nIORST, .nFCS_i, .nDTACK_i(nDTACK_o), .nSLAVEN_i(nSLAVEN_o),
	.dataOe_i(dataOe_o), .nCFGOUTN_i(nCFGOUTN_o)
);

// File: test/zorroSlaveTb.sv
// one card with the default 256-longword memory; the chain input is held low and no other card shares the bus
`timescale 1ns/1ps

module zorroSlaveTb import zorroPkg::*; ();

	localparam int MemWords = 256;

	logic clk = 1'b0;
	logic nIORST;
	logic nFCS, busRead, doe, nCfgIn;
	logic [3:0] nDS;
	logic [1:0] fc;
	logic [7:2] addrLo;
	logic [31:8] adIn;
	logic [7:0] sdIn;
	logic nSlaven, nDtack, nCfgOut, dataOe;
	logic [31:8] adOut;
	logic [7:0] sdOut;

	// reference model of the card memory, one longword per index
	logic [31:0] modelMem [MemWords];
	logic [15:0] cardBase;
	logic [15:0] otherHi;
	logic [31:0] rdData;
	logic [31:0] wrData;
	logic [15:0] offset;
	logic [3:0] strobes;
	int unsigned seedDiscard;

	always #4 clk = ~clk;

	zorroSlaveTop dut_i (
		.clk, .nIORST, .nFCS_i(nFCS), .READ_i(busRead), .DOE_i(doe), .nDS_i(nDS),
		.FC_i(fc), .A_i(addrLo), .adIn_i(adIn), .sdIn_i(sdIn), .nCFGINN_i(nCfgIn),
		.nSLAVEN_o(nSlaven), .nDTACK_o(nDtack), .nCFGOUTN_o(nCfgOut),
		.adOut_o(adOut), .sdOut_o(sdOut), .dataOe_o(dataOe)
	);

	task automatic failNow(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
			$display("tests failed");
			$fatal(1, "mismatch");
		end
	endtask

	// all drives land 1 ns after the rising edge
	task automatic stepClock();
		@(posedge clk);
		#1;
	endtask

	task automatic applyReset();
		nIORST = 1'b0;
		nFCS = 1'b1;
		doe = 1'b0;
		nDS = 4'hF;
		repeat (16) @(posedge clk);
		#1;
		nIORST = 1'b1;
		@(negedge clk);
		checkEq("nSLAVEN_o", nSlaven, 1'b1);
		checkEq("nDTACK_o", nDtack, 1'b1);
		checkEq("nCFGOUTN_o", nCfgOut, 1'b1);
		checkEq("dataOe_o", dataOe, 1'b0);
	endtask

	// one full cycle as a bus master; a miss ends on timeout instead of nDTACK
	task automatic busCycle(input logic [31:0] addr, input logic [1:0] fcVal, input logic isRead,
			input logic [3:0] laneMask, input logic [31:0] data, input logic expectHit,
			output logic [31:0] rdWord);
		int cnt;
		logic seen;
		logic slaveSeen;
		rdWord = '0;
		stepClock();
		addrLo = addr[7:2];
		adIn = addr[31:8];
		fc = fcVal;
		busRead = isRead;
		nFCS = 1'b0;
		stepClock();
		doe = 1'b1;
		if (!isRead) begin
			// D23..16 goes on SD, the rest on AD
			adIn = {data[31:24], data[15:0]};
			sdIn = data[23:16];
			stepClock();
			nDS = ~laneMask;
		end
		seen = 1'b0;
		slaveSeen = 1'b0;
		cnt = 0;
		while (!seen && cnt < 16) begin
			@(negedge clk);
			if (!expectHit) begin
				checkEq("nSLAVEN_o", nSlaven, 1'b1);
			end
			slaveSeen = slaveSeen || !nSlaven;
			if (!nDtack) begin
				seen = 1'b1;
			end else begin
				cnt++;
			end
		end
		if (expectHit && !seen) failNow("no nDTACK from the card within the timeout");
		if (!expectHit && seen) failNow("nDTACK came for a cycle the card must ignore");
		if (expectHit && !slaveSeen) failNow("nSLAVEN never went low for an addressed cycle");
		if (isRead && seen) begin
			checkEq("dataOe_o", dataOe, 1'b1);
			rdWord = {adOut[31:24], sdOut, adOut[23:8]};
		end
		stepClock();
		nFCS = 1'b1;
		doe = 1'b0;
		nDS = 4'hF;
		cnt = 0;
		while (!nDtack && cnt < 4) begin
			@(negedge clk);
			cnt++;
		end
		if (!nDtack) failNow("nDTACK stayed low after nFCS went high");
	endtask

	task automatic waitChainOut();
		int cnt;
		cnt = 0;
		while (nCfgOut && cnt < 8) begin
			@(negedge clk);
			cnt++;
		end
		if (nCfgOut) failNow("nCFGOUTN did not fall after the configuration write");
	endtask

	// register 0 reads true, others inverted, nibble in D31..28
	function automatic logic [31:0] cfgExpect(input int regNum, input logic lowHalf);
		logic [7:0] regByte;
		logic [3:0] nib;
		regByte = CfgRom[regNum];
		nib = lowHalf ? regByte[3:0] : regByte[7:4];
		if (regNum != 0) nib = ~nib;
		return {nib, 28'h0};
	endfunction

	// a contiguous run of one to four lanes
	function automatic logic [3:0] randomStrobes();
		int first;
		int len;
		first = $urandom % 4;
		len = 1 + $urandom % (4 - first);
		return 4'(((1 << len) - 1) << first);
	endfunction

	function automatic logic [1:0] dataFc();
		return ($urandom % 2) ? 2'b01 : 2'b10;
	endfunction

	initial begin
		seedDiscard = $urandom(32'hb4485414);
		nIORST = 1'b0;
		nFCS = 1'b1;
		busRead = 1'b1;
		doe = 1'b0;
		nDS = 4'hF;
		fc = 2'b01;
		addrLo = '0;
		adIn = '0;
		sdIn = '0;
		nCfgIn = 1'b0;
		applyReset();

		// walk the whole autoconfig table, both nibbles
		for (int r = 0; r < 16; r++) begin
			for (int h = 0; h < 2; h++) begin
				busCycle(32'hFF00_0000 | (h << 8) | (r << 2), dataFc(), 1'b1, 4'h0, '0, 1'b1, rdData);
				checkEq("config data", rdData, cfgExpect(r, h[0]));
			end
		end

		do begin
			cardBase = 16'($urandom);
		end while (cardBase == CfgSpaceHi);
		wrData = {cardBase, 16'($urandom)};
		busCycle({CfgSpaceHi, 7'h0, CfgBaseOffset}, dataFc(), 1'b0, 4'hF, wrData, 1'b1, rdData);
		waitChainOut();
		busCycle(32'hFF00_0000, dataFc(), 1'b1, 4'h0, '0, 1'b0, rdData);

		// fill every longword so later reads compare whole words
		for (int i = 0; i < MemWords; i++) begin
			wrData = $urandom;
			offset = {6'($urandom), 8'(i), 2'b00};
			busCycle({cardBase, offset}, dataFc(), 1'b0, 4'hF, wrData, 1'b1, rdData);
			modelMem[i] = wrData;
		end

		repeat (300) begin
			offset = {14'($urandom), 2'b00};
			if ($urandom % 2) begin
				wrData = $urandom;
				strobes = randomStrobes();
				busCycle({cardBase, offset}, dataFc(), 1'b0, strobes, wrData, 1'b1, rdData);
				for (int k = 0; k < 4; k++) begin
					if (strobes[k]) modelMem[offset[9:2]][8*k +: 8] = wrData[8*k +: 8];
				end
			end else begin
				busCycle({cardBase, offset}, dataFc(), 1'b1, 4'h0, '0, 1'b1, rdData);
				checkEq("card data", rdData, modelMem[offset[9:2]]);
			end
		end

		// foreign addresses and wrong function codes
		repeat (20) begin
			do begin
				otherHi = 16'($urandom);
			end while (otherHi == cardBase || otherHi == CfgSpaceHi);
			busCycle({otherHi, 14'($urandom), 2'b00}, dataFc(), 1'($urandom), 4'hF,
				$urandom, 1'b0, rdData);
			busCycle({cardBase, 14'($urandom), 2'b00}, ($urandom % 2) ? 2'b00 : 2'b11,
				1'($urandom), 4'hF, $urandom, 1'b0, rdData);
		end

		// shut-up after a fresh reset
		applyReset();
		busCycle({CfgSpaceHi, 7'h0, CfgShutupOffset}, dataFc(), 1'b0, 4'hF, $urandom, 1'b1, rdData);
		waitChainOut();
		busCycle(32'hFF00_0000, dataFc(), 1'b1, 4'h0, '0, 1'b0, rdData);
		busCycle({cardBase, 16'h0000}, dataFc(), 1'b1, 4'h0, '0, 1'b0, rdData);

		$display("all tests passed");
		$finish;
	end

endmodule

// File: project.f
logic/zorroPkg.sv
logic/zorroAddrDecode.sv
logic/zorroAutoconfig.sv
logic/zorroCycleCtrl.sv
logic/byteLaneRam.sv
logic/zorroDataDrive.sv
logic/zorroSlaveTop.sv
test/zorroSlave_props.sv
test/zorroSlaveTb.sv

// File: Bender.yml
package:
  name: zorro_slave

sources:
  - files:
      - logic/zorroPkg.sv
      - logic/zorroAddrDecode.sv
      - logic/zorroAutoconfig.sv
      - logic/zorroCycleCtrl.sv
      - logic/byteLaneRam.sv
      - logic/zorroDataDrive.sv
      - logic/zorroSlaveTop.sv
  - target: test
    files:
      - test/zorroSlave_props.sv
      - test/zorroSlaveTb.sv
